// File: sources.f
common/rv32_isa_pkg.sv
common/decode_ctrl_pkg.sv
common/decode_fields_if.sv
design/opcode_classifier.sv
design/fault_checker.sv
design/immediate_builder.sv
design/stage_control.sv
design/instruction_decoder.sv
verification/instruction_decoder_sva.sv
verification/tb_instruction_decoder.sv

// File: verification/tb_instruction_decoder.sv
`timescale 1ns/1ns

module tb_instruction_decoder import rv32_isa_pkg::*, decode_ctrl_pkg::*; ();

    localparam int rf_bits = 4;
    localparam int reset_timeout = 10;
    localparam int random_count = 64;
    localparam opcode_t opc_fence = 7'b0001111;
    localparam opcode_t opc_system = 7'b1110011;

    typedef struct {
        string name;
        instr_t instr;
        logic fault;
        word_t imm;
        wb_sel_t wb_sel;
        pc_sel_t pc_sel;
        alu_uop_t alu_uop;
        mem_uop_t mem_uop;
        logic a_sel;
        logic b_sel;
        logic [2*rf_bits+1:0] rd_uop;
        logic [2*rf_bits+1:0] wb_uop;
    } vector_t;

    logic clk;
    logic rst_n;
    instr_t instr;
    word_t imm;
    logic alu_a_sel;
    logic alu_b_sel;
    wb_sel_t wb_sel;
    pc_sel_t pc_sel;
    logic [2*rf_bits+1:0] rd_rf_uop;
    alu_uop_t ex_alu_uop;
    mem_uop_t ma_mem_uop;
    logic [2*rf_bits+1:0] wb_rf_uop;
    logic fault;
    vector_t vectors[$];
    logic [31:0] rng_state;

    instruction_decoder #(
        .rf_addr_bits(rf_bits)
    ) dut_i (
        .clk(clk),
        .rst_n(rst_n),
        .instr(instr),
        .imm(imm),
        .alu_a_sel(alu_a_sel),
        .alu_b_sel(alu_b_sel),
        .wb_sel(wb_sel),
        .pc_sel(pc_sel),
        .rd_rf_uop(rd_rf_uop),
        .ex_alu_uop(ex_alu_uop),
        .ma_mem_uop(ma_mem_uop),
        .wb_rf_uop(wb_rf_uop),
        .fault(fault)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n <= 1'b1; // Main loop sees it one falling edge later
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic is_kept_opcode(input opcode_t opc);
        return opc inside {opc_lui, opc_auipc, opc_jal, opc_jalr, opc_branch,
            opc_load, opc_store, opc_opimm, opc_op};
    endfunction

    // Instruction encoders by format
    function automatic instr_t r_type(input funct7_t f7, input reg_field_t rs2,
        input reg_field_t rs1, input funct3_t f3, input reg_field_t rd);
        return {f7, rs2, rs1, f3, rd, opc_op};
    endfunction

    function automatic instr_t i_type(input logic [11:0] i, input reg_field_t rs1,
        input funct3_t f3, input reg_field_t rd, input opcode_t opc);
        return {i, rs1, f3, rd, opc};
    endfunction

    function automatic instr_t s_type(input logic [11:0] i, input reg_field_t rs2,
        input reg_field_t rs1, input funct3_t f3);
        return {i[11:5], rs2, rs1, f3, i[4:0], opc_store};
    endfunction

    function automatic instr_t b_type(input logic [12:0] i, input reg_field_t rs2,
        input reg_field_t rs1, input funct3_t f3);
        return {i[12], i[10:5], rs2, rs1, f3, i[4:1], i[11], opc_branch};
    endfunction

    function automatic instr_t u_type(input logic [19:0] i, input reg_field_t rd,
        input opcode_t opc);
        return {i, rd, opc};
    endfunction

    function automatic instr_t j_type(input logic [20:0] i, input reg_field_t rd);
        return {i[20], i[10:1], i[11], i[19:12], rd, opc_jal};
    endfunction

    task automatic add_vector(input string name, input instr_t ins, input logic flt,
        input word_t im, input wb_sel_t wb, input pc_sel_t pc, input alu_uop_t alu,
        input mem_uop_t mem, input logic a_sel, input logic b_sel,
        input logic [2*rf_bits+1:0] rd_uop, input logic [2*rf_bits+1:0] wb_uop);
        vector_t v;
        v.name = name;
        v.instr = ins;
        v.fault = flt;
        v.imm = im;
        v.wb_sel = wb;
        v.pc_sel = pc;
        v.alu_uop = alu;
        v.mem_uop = mem;
        v.a_sel = a_sel;
        v.b_sel = b_sel;
        v.rd_uop = rd_uop;
        v.wb_uop = wb_uop;
        vectors.push_back(v);
    endtask

    task automatic load_vectors();
        add_vector("lui", u_type(20'h12345, 5'd5, opc_lui), 1'b0, 32'h12345000,
            wb_sel_imm, pc_sel_npc, 6'h00, 5'h05, 1'b0, 1'b1, 10'h083, 10'h350);
        add_vector("auipc_neg", u_type(20'hfffff, 5'd1, opc_auipc), 1'b0, 32'hfffff000,
            wb_sel_alu, pc_sel_npc, 6'h20, 5'h07, 1'b1, 1'b1, 10'h0ff, 10'h310);
        add_vector("jal_neg", j_type(21'h1ffff8, 5'd1), 1'b0, 32'hfffffff8,
            wb_sel_npc, pc_sel_jal, 6'h00, 5'h07, 1'b0, 1'b1, 10'h0f9, 10'h310);
        add_vector("jalr", i_type(12'h004, 5'd2, 3'b000, 5'd1, opc_jalr), 1'b0, 32'h4,
            wb_sel_npc, pc_sel_jalr, 6'h20, 5'h00, 1'b0, 1'b1, 10'h224, 10'h310);
        add_vector("bne_neg", b_type(13'h1ff0, 5'd4, 5'd3, 3'b001), 1'b0, 32'hfffffff0,
            wb_sel_alu, pc_sel_branch, 6'h31, 5'h01, 1'b0, 1'b0, 10'h234, 10'h110);
        add_vector("lw_neg", i_type(12'hffc, 5'd2, 3'b010, 5'd6, opc_load), 1'b0,
            32'hfffffffc, wb_sel_mem, pc_sel_npc, 6'h20, 5'h12,
            1'b0, 1'b1, 10'h22c, 10'h360);
        add_vector("sw", s_type(12'h07c, 5'd7, 5'd2, 3'b010), 1'b0, 32'h7c,
            wb_sel_alu, pc_sel_npc, 6'h20, 5'h1a, 1'b0, 1'b1, 10'h227, 10'h1c0);
        add_vector("addi_neg", i_type(12'h800, 5'd1, 3'b000, 5'd2, opc_opimm), 1'b0,
            32'hfffff800, wb_sel_alu, pc_sel_npc, 6'h20, 5'h00,
            1'b0, 1'b1, 10'h210, 10'h320);
        add_vector("srai", i_type({funct7_alt, 5'd3}, 5'd1, 3'b101, 5'd2, opc_opimm), 1'b0,
            32'h403, wb_sel_alu, pc_sel_npc, 6'h2d, 5'h05,
            1'b0, 1'b1, 10'h213, 10'h320);
        add_vector("add", r_type(7'h00, 5'd3, 5'd2, 3'b000, 5'd1), 1'b0, 32'h3,
            wb_sel_alu, pc_sel_npc, 6'h20, 5'h00, 1'b0, 1'b0, 10'h223, 10'h310);
        add_vector("sub", r_type(funct7_alt, 5'd3, 5'd2, 3'b000, 5'd1), 1'b0, 32'h403,
            wb_sel_alu, pc_sel_npc, 6'h28, 5'h00, 1'b0, 1'b0, 10'h223, 10'h310);
        // Field faults
        add_vector("jalr_f3", i_type(12'h000, 5'd1, 3'b001, 5'd1, opc_jalr), 1'b1, 32'h0,
            wb_sel_npc, pc_sel_jalr, 6'h20, 5'h01, 1'b0, 1'b1, 10'h210, 10'h310);
        add_vector("load_f3", i_type(12'h000, 5'd1, 3'b011, 5'd1, opc_load), 1'b1, 32'h0,
            wb_sel_mem, pc_sel_npc, 6'h20, 5'h13, 1'b0, 1'b1, 10'h210, 10'h310);
        add_vector("branch_f3", b_type(13'h0008, 5'd1, 5'd1, 3'b010), 1'b1, 32'h8,
            wb_sel_alu, pc_sel_branch, 6'h32, 5'h02, 1'b0, 1'b0, 10'h211, 10'h180);
        add_vector("sll_alt", r_type(funct7_alt, 5'd3, 5'd2, 3'b001, 5'd1), 1'b1, 32'h403,
            wb_sel_alu, pc_sel_npc, 6'h21, 5'h01, 1'b0, 1'b0, 10'h223, 10'h310);
        add_vector("slli_f7", i_type(12'h022, 5'd1, 3'b001, 5'd2, opc_opimm), 1'b1, 32'h22,
            wb_sel_alu, pc_sel_npc, 6'h21, 5'h01, 1'b0, 1'b1, 10'h212, 10'h320);
        add_vector("rs1_x17", r_type(7'h00, 5'd3, 5'd17, 3'b000, 5'd1), 1'b1, 32'h3,
            wb_sel_alu, pc_sel_npc, 6'h20, 5'h00, 1'b0, 1'b0, 10'h213, 10'h310);
        add_vector("lui_x16", u_type(20'h00001, 5'd16, opc_lui), 1'b1, 32'h1000,
            wb_sel_imm, pc_sel_npc, 6'h00, 5'h01, 1'b0, 1'b1, 10'h000, 10'h300);
    endtask

    task automatic abort_run();
        $display("Some tests failed");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic check_value(input string name, input string what,
        input logic [31:0] expected, input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("ERR %s %s expected %h actual %h", name, what, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_reset_outputs();
        check_value("reset", "fault", 32'h0, fault);
        check_value("reset", "imm", 32'h0, imm);
        check_value("reset", "alu_a_sel", 32'h0, alu_a_sel);
        check_value("reset", "alu_b_sel", 32'h0, alu_b_sel);
        check_value("reset", "wb_sel", 32'h0, wb_sel);
        check_value("reset", "pc_sel", 32'h0, pc_sel);
        check_value("reset", "rd_rf_uop", 32'h0, rd_rf_uop);
        check_value("reset", "ex_alu_uop", 32'h0, ex_alu_uop);
        check_value("reset", "ma_mem_uop", 32'h0, ma_mem_uop);
        check_value("reset", "wb_rf_uop", 32'h0, wb_rf_uop);
    endtask

    task automatic check_vector(input vector_t v);
        check_value(v.name, "fault", v.fault, fault);
        check_value(v.name, "imm", v.imm, imm);
        check_value(v.name, "wb_sel", v.wb_sel, wb_sel);
        check_value(v.name, "pc_sel", v.pc_sel, pc_sel);
        check_value(v.name, "ex_alu_uop", v.alu_uop, ex_alu_uop);
        check_value(v.name, "ma_mem_uop", v.mem_uop, ma_mem_uop);
        check_value(v.name, "alu_a_sel", v.a_sel, alu_a_sel);
        check_value(v.name, "alu_b_sel", v.b_sel, alu_b_sel);
        check_value(v.name, "rd_rf_uop", v.rd_uop, rd_rf_uop);
        check_value(v.name, "wb_rf_uop", v.wb_uop, wb_rf_uop);
    endtask

    initial begin
        int cycles;
        opcode_t opc;
        instr = '0;
        rng_state = 32'd15;
        cycles = 0;
        load_vectors();
        @(posedge clk);
        @(negedge clk);
        while (rst_n !== 1'b1) begin
            check_reset_outputs();
            cycles++;
            if (cycles > reset_timeout) begin
                $display("Reset was not released within %0d cycles", reset_timeout);
                abort_run();
            end
            @(negedge clk);
        end
        foreach (vectors[i]) begin
            instr = vectors[i].instr;
            @(negedge clk); // Decoded one cycle later
            check_vector(vectors[i]);
        end
        for (int k = 0; k < random_count; k++) begin
            rng_state = xorshift(rng_state);
            opc = rng_state[6:0];
            if (k == 0) begin
                opc = opc_fence;
            end else if (k == 1) begin
                opc = opc_system;
            end else if (is_kept_opcode(opc)) begin
                opc = opc ^ 7'b0000001; // Low bits no longer 11
            end
            instr = {rng_state[31:7], opc};
            @(negedge clk);
            check_value($sformatf("random_%0d", k), "fault", 32'h1, fault);
        end
        $display("All tests passed");
        $finish;
    end

endmodule

// File: verification/instruction_decoder_sva.sv
`timescale 1ns/1ns

module instruction_decoder_sva import rv32_isa_pkg::*, decode_ctrl_pkg::*; #(
    parameter int rf_addr_bits = 4
) (
    input logic clk,
    input logic rst_n,
    input word_t imm,
    input logic alu_a_sel,
    input logic alu_b_sel,
    input wb_sel_t wb_sel,
    input pc_sel_t pc_sel,
    input logic [2*rf_addr_bits+1:0] rd_rf_uop,
    input alu_uop_t ex_alu_uop,
    input mem_uop_t ma_mem_uop,
    input logic [2*rf_addr_bits+1:0] wb_rf_uop,
    input logic fault
);

    reset_clears_outputs: assert property (@(posedge clk) !rst_n |=>
        (imm == '0 && !alu_a_sel && !alu_b_sel && wb_sel == '0 && pc_sel == '0 &&
        rd_rf_uop == '0 && ex_alu_uop == '0 && ma_mem_uop == '0 &&
        wb_rf_uop == '0 && !fault))
        else $error("outputs not cleared one cycle after reset");

    branch_needs_compare: assert property (@(posedge clk) disable iff (!rst_n)
        (pc_sel == pc_sel_branch) |-> ex_alu_uop[alu_branch_bit])
        else $error("branch pc select without ALU compare flag");

    no_mem_with_link: assert property (@(posedge clk) disable iff (!rst_n)
        !(ma_mem_uop[mem_en_bit] && wb_sel == wb_sel_npc))
        else $error("memory access together with link write-back");

endmodule

bind instruction_decoder instruction_decoder_sva #(
    .rf_addr_bits(rf_addr_bits)
) sva_i (.*);

// File: design/instruction_decoder.sv
`timescale 1ns/1ns

module instruction_decoder import rv32_isa_pkg::*, decode_ctrl_pkg::*; #(
    parameter int rf_addr_bits = 4
) (
    input logic clk,
    input logic rst_n,
    input instr_t instr,
    output word_t imm,
    output logic alu_a_sel, // 0 rs1, 1 pc
    output logic alu_b_sel, // 0 rs2, 1 imm
    output wb_sel_t wb_sel,
    output pc_sel_t pc_sel,
    output logic [2*rf_addr_bits+1:0] rd_rf_uop,
    output alu_uop_t ex_alu_uop,
    output mem_uop_t ma_mem_uop,
    output logic [2*rf_addr_bits+1:0] wb_rf_uop,
    output logic fault
);

    decode_fields_if fields_if ();

    opcode_classifier classifier_i (
        .instr(instr),
        .fields(fields_if)
    );

    fault_checker #(
        .rf_addr_bits(rf_addr_bits)
    ) fault_i (
        .clk(clk),
        .rst_n(rst_n),
        .fields(fields_if),
        .fault(fault)
    );

    immediate_builder imm_i (
        .clk(clk),
        .rst_n(rst_n),
        .fields(fields_if),
        .imm(imm)
    );

    stage_control #(
        .rf_addr_bits(rf_addr_bits)
    ) ctrl_i (
        .clk(clk),
        .rst_n(rst_n),
        .fields(fields_if),
        .alu_a_sel(alu_a_sel),
        .alu_b_sel(alu_b_sel),
        .wb_sel(wb_sel),
        .pc_sel(pc_sel),
        .rd_rf_uop(rd_rf_uop),
        .ex_alu_uop(ex_alu_uop),
        .ma_mem_uop(ma_mem_uop),
        .wb_rf_uop(wb_rf_uop)
    );

endmodule

// File: design/stage_control.sv
`timescale 1ns/1ns

module stage_control import rv32_isa_pkg::*, decode_ctrl_pkg::*; #(
    parameter int rf_addr_bits = 4
) (
    input logic clk,
    input logic rst_n,
    decode_fields_if.consumer fields,
    output logic alu_a_sel,
    output logic alu_b_sel,
    output wb_sel_t wb_sel,
    output pc_sel_t pc_sel,
    output logic [2*rf_addr_bits+1:0] rd_rf_uop,
    output alu_uop_t ex_alu_uop,
    output mem_uop_t ma_mem_uop,
    output logic [2*rf_addr_bits+1:0] wb_rf_uop
);

    opcode_class_e cls;
    logic valid;
    logic rd_en;
    logic wb_en;
    logic is_mem;
    logic alt_op;
    logic alt_opimm;
    alu_uop_t alu_next;
    mem_uop_t mem_next;
    wb_sel_t wb_next;
    pc_sel_t pc_next;

    assign cls = fields.opclass;
    assign valid = (cls != class_invalid); // Faulting opcodes get no enables
    assign rd_en = valid && !(cls inside {class_lui, class_auipc, class_jal});
    assign wb_en = valid && !(cls inside {class_store, class_branch});
    assign is_mem = (cls == class_load) || (cls == class_store);
    assign alt_op = (cls == class_op) && (fields.funct3 inside {3'b000, 3'b101});
    assign alt_opimm = (cls == class_opimm) && (fields.funct3 == 3'b101);

    always_comb begin
        alu_next = '0;
        alu_next[alu_en_bit] = valid && !(cls inside {class_lui, class_jal});
        alu_next[alu_branch_bit] = (cls == class_branch);
        alu_next[alu_alt_bit] = fields.funct7[5] && (alt_op || alt_opimm);
        if (cls inside {class_op, class_opimm, class_branch}) begin
            alu_next[alu_fn_lsb +: 3] = fields.funct3;
        end
        mem_next = '0;
        mem_next[mem_en_bit] = is_mem;
        mem_next[mem_store_bit] = (cls == class_store);
        mem_next[mem_fn_lsb +: 3] = fields.funct3; // Width and sign
        case (cls)
            class_lui: wb_next = wb_sel_imm;
            class_load: wb_next = wb_sel_mem;
            class_jal, class_jalr: wb_next = wb_sel_npc;
            default: wb_next = wb_sel_alu;
        endcase
        case (cls)
            class_jalr: pc_next = pc_sel_jalr;
            class_jal: pc_next = pc_sel_jal;
            class_branch: pc_next = pc_sel_branch;
            default: pc_next = pc_sel_npc;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            alu_a_sel <= 1'b0;
            alu_b_sel <= 1'b0;
            wb_sel <= wb_sel_alu;
            pc_sel <= pc_sel_npc;
            rd_rf_uop <= '0;
            ex_alu_uop <= '0;
            ma_mem_uop <= '0;
            wb_rf_uop <= '0;
        end else begin
            alu_a_sel <= (cls == class_auipc); // PC as operand A
            alu_b_sel <= !(cls inside {class_op, class_branch});
            wb_sel <= wb_next;
            pc_sel <= pc_next;
            rd_rf_uop <= {rd_en, 1'b0, fields.rs1[rf_addr_bits-1:0],
                fields.rs2[rf_addr_bits-1:0]};
            ex_alu_uop <= alu_next;
            ma_mem_uop <= mem_next;
            wb_rf_uop <= {wb_en, 1'b1, fields.rd[rf_addr_bits-1:0], {rf_addr_bits{1'b0}}};
        end
    end

endmodule

// File: design/immediate_builder.sv
`timescale 1ns/1ns

module immediate_builder import rv32_isa_pkg::*; (
    input logic clk,
    input logic rst_n,
    decode_fields_if.consumer fields,
    output word_t imm
);

    instr_t ir;
    word_t imm_next;

    assign ir = fields.instr;

    always_comb begin
        case (fields.opclass)
            class_lui, class_auipc: begin
                imm_next = {ir[31:12], 12'b0}; // U format
            end
            class_jal: begin
                imm_next = {{12{ir[31]}}, ir[19:12], ir[20], ir[30:21], 1'b0};
            end
            class_branch: begin
                imm_next = {{20{ir[31]}}, ir[7], ir[30:25], ir[11:8], 1'b0};
            end
            class_store: begin
                imm_next = {{20{ir[31]}}, ir[31:25], ir[11:7]};
            end
            default: begin
                imm_next = {{20{ir[31]}}, ir[31:20]}; // I format
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            imm <= '0;
        end else begin
            imm <= imm_next;
        end
    end

endmodule

// File: design/fault_checker.sv
`timescale 1ns/1ns

module fault_checker import rv32_isa_pkg::*; #(
    parameter int rf_addr_bits = 4
) (
    input logic clk,
    input logic rst_n,
    decode_fields_if.consumer fields,
    output logic fault
);

    logic reads_rs1;
    logic reads_rs2;
    logic writes_rd;
    logic bad_funct3;
    logic bad_funct7;
    logic bad_reg;
    logic f7_zero;
    logic f7_alt;

    assign f7_zero = (fields.funct7 == '0);
    assign f7_alt = (fields.funct7 == funct7_alt);

    always_comb begin
        reads_rs1 = 1'b0;
        reads_rs2 = 1'b0;
        writes_rd = 1'b0;
        bad_funct3 = 1'b0;
        bad_funct7 = 1'b0;
        case (fields.opclass)
            class_lui, class_auipc, class_jal: begin
                writes_rd = 1'b1;
            end
            class_jalr: begin
                reads_rs1 = 1'b1;
                writes_rd = 1'b1;
                bad_funct3 = (fields.funct3 != 3'b000);
            end
            class_branch: begin
                reads_rs1 = 1'b1;
                reads_rs2 = 1'b1;
                bad_funct3 = (fields.funct3[2:1] == 2'b01); // 010, 011
            end
            class_load: begin
                reads_rs1 = 1'b1;
                writes_rd = 1'b1;
                bad_funct3 = (fields.funct3 == 3'b011) || (fields.funct3[2:1] == 2'b11);
            end
            class_store: begin
                reads_rs1 = 1'b1;
                reads_rs2 = 1'b1;
                bad_funct3 = fields.funct3[2] || (fields.funct3[1:0] == 2'b11);
            end
            class_opimm: begin
                reads_rs1 = 1'b1;
                writes_rd = 1'b1;
                if (fields.funct3 == 3'b001) begin
                    bad_funct7 = !f7_zero; // SLLI
                end else if (fields.funct3 == 3'b101) begin
                    bad_funct7 = !(f7_zero || f7_alt); // SRLI, SRAI
                end
            end
            class_op: begin
                reads_rs1 = 1'b1;
                reads_rs2 = 1'b1;
                writes_rd = 1'b1;
                bad_funct7 = !(f7_zero ||
                    (f7_alt && (fields.funct3 == 3'b000 || fields.funct3 == 3'b101)));
            end
            default: begin
            end
        endcase
    end

    // Specifier bits beyond the register file
    assign bad_reg = (reads_rs1 && (|(fields.rs1 >> rf_addr_bits))) ||
        (reads_rs2 && (|(fields.rs2 >> rf_addr_bits))) ||
        (writes_rd && (|(fields.rd >> rf_addr_bits)));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fault <= 1'b0;
        end else begin
            fault <= (fields.opclass == class_invalid) || bad_funct3 || bad_funct7 || bad_reg;
        end
    end

endmodule

// File: design/opcode_classifier.sv
`timescale 1ns/1ns

module opcode_classifier import rv32_isa_pkg::*; (
    input instr_t instr,
    decode_fields_if.producer fields
);

    opcode_t opcode;

    assign opcode = instr[6:0];

    assign fields.instr = instr;
    assign fields.rd = instr[11:7];
    assign fields.funct3 = instr[14:12];
    assign fields.rs1 = instr[19:15];
    assign fields.rs2 = instr[24:20];
    assign fields.funct7 = instr[31:25];

    // Only legality decision for the opcode
    always_comb begin
        case (opcode)
            opc_lui: begin
                fields.opclass = class_lui;
            end
            opc_auipc: begin
                fields.opclass = class_auipc;
            end
            opc_jal: begin
                fields.opclass = class_jal;
            end
            opc_jalr: begin
                fields.opclass = class_jalr;
            end
            opc_branch: begin
                fields.opclass = class_branch;
            end
            opc_load: begin
                fields.opclass = class_load;
            end
            opc_store: begin
                fields.opclass = class_store;
            end
            opc_opimm: begin
                fields.opclass = class_opimm;
            end
            opc_op: begin
                fields.opclass = class_op;
            end
            default: begin
                fields.opclass = class_invalid; // FENCE, SYSTEM, compressed, reserved
            end
        endcase
    end

endmodule

// File: common/decode_fields_if.sv
`timescale 1ns/1ns

interface decode_fields_if import rv32_isa_pkg::*; ();

    opcode_class_e opclass;
    reg_field_t rd;
    reg_field_t rs1;
    reg_field_t rs2;
    funct3_t funct3;
    funct7_t funct7;
    instr_t instr; // Raw word, immediates need scattered bits

    modport producer (
        output opclass, rd, rs1, rs2, funct3, funct7, instr
    );

    modport consumer (
        input opclass, rd, rs1, rs2, funct3, funct7, instr
    );

endinterface

// File: common/decode_ctrl_pkg.sv
package decode_ctrl_pkg;

    typedef logic [5:0] alu_uop_t; // {en, branch, alt, funct3}
    typedef logic [4:0] mem_uop_t; // {en, store, funct3}
    typedef logic [1:0] wb_sel_t;
    typedef logic [1:0] pc_sel_t;

    // ALU microcode bit positions
    localparam int alu_en_bit = 5;
    localparam int alu_branch_bit = 4;
    localparam int alu_alt_bit = 3;
    localparam int alu_fn_lsb = 0;

    // Memory microcode bit positions
    localparam int mem_en_bit = 4;
    localparam int mem_store_bit = 3;
    localparam int mem_fn_lsb = 0;

    // Write-back source
    localparam wb_sel_t wb_sel_alu = 2'd0;
    localparam wb_sel_t wb_sel_imm = 2'd1;
    localparam wb_sel_t wb_sel_mem = 2'd2;
    localparam wb_sel_t wb_sel_npc = 2'd3; // Link address

    // Next PC source
    localparam pc_sel_t pc_sel_npc = 2'd0;
    localparam pc_sel_t pc_sel_jalr = 2'd1;
    localparam pc_sel_t pc_sel_jal = 2'd2;
    localparam pc_sel_t pc_sel_branch = 2'd3; // Taken only if compare holds

endpackage

// File: common/rv32_isa_pkg.sv
package rv32_isa_pkg;

    typedef logic [31:0] instr_t;
    typedef logic [6:0] opcode_t;
    typedef logic [2:0] funct3_t;
    typedef logic [6:0] funct7_t;
    typedef logic [4:0] reg_field_t; // Register specifier as encoded
    typedef logic [31:0] word_t;

    // Major opcode groups that the decoder accepts
    typedef enum logic [3:0] {
        class_invalid,
        class_lui,
        class_auipc,
        class_jal,
        class_jalr,
        class_branch,
        class_load,
        class_store,
        class_opimm,
        class_op
    } opcode_class_e;

    localparam opcode_t opc_lui = 7'b0110111;
    localparam opcode_t opc_auipc = 7'b0010111;
    localparam opcode_t opc_jal = 7'b1101111;
    localparam opcode_t opc_jalr = 7'b1100111;
    localparam opcode_t opc_branch = 7'b1100011;
    localparam opcode_t opc_load = 7'b0000011;
    localparam opcode_t opc_store = 7'b0100011;
    localparam opcode_t opc_opimm = 7'b0010011;
    localparam opcode_t opc_op = 7'b0110011;

    localparam funct7_t funct7_alt = 7'b0100000; // SUB, SRA, SRAI

endpackage
